/* project.f */
rtl/tetris_types_pkg.sv
rtl/tetris_geom_pkg.sv
rtl/cmd_fifo.sv
rtl/piece_rng.sv
rtl/piece_shape.sv
rtl/bound_check.sv
rtl/move_ctrl.sv
rtl/cell_lookup.sv
rtl/tetris_piece_top.sv
verif/tetris_piece_asserts.sv
verif/tetris_piece_tb.sv

/* rtl/bound_check.sv */
`timescale 1ns/1ps
`default_nettype none

module bound_check (
	input tetris_types_pkg::shape_t shape,
	input tetris_geom_pkg::row_t row,
	input tetris_geom_pkg::col_t col,
	output logic collide
);

	// Only walls and floor count, there is no locked stack
	always_comb begin
		int well_row;
		int well_col;
		collide = 1'b0;
		for (int r = 0; r < tetris_geom_pkg::GRID_SIZE; r++) begin
			for (int c = 0; c < tetris_geom_pkg::GRID_SIZE; c++) begin
				well_row = int'(row) + r;
				well_col = int'(col) + c;
				if (shape[tetris_geom_pkg::grid_bit(r, c)]) begin
					if (well_row >= tetris_geom_pkg::WELL_ROWS)
						collide = 1'b1;
					if (well_col < 0 || well_col >= tetris_geom_pkg::WELL_COLS)
						collide = 1'b1;
				end
			end
		end
	end

endmodule : bound_check

`default_nettype wire

/* rtl/cell_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

module cell_lookup (
	input tetris_types_pkg::shape_t shape,
	input tetris_types_pkg::tile_t color,
	input tetris_geom_pkg::row_t piece_row,
	input tetris_geom_pkg::col_t piece_col,
	input logic playing,
	input tetris_geom_pkg::cell_row_t query_row,
	input tetris_geom_pkg::cell_col_t query_col,
	output tetris_types_pkg::tile_t query_tile
);

	always_comb begin
		int grid_row;
		int grid_col;
		query_tile = tetris_types_pkg::TILE_EMPTY;
		// Offset of the queried cell inside the piece grid
		grid_row = int'(query_row) - int'(piece_row);
		grid_col = int'(query_col) - int'(piece_col);
		if (playing && grid_row >= 0 && grid_row < tetris_geom_pkg::GRID_SIZE &&
			grid_col >= 0 && grid_col < tetris_geom_pkg::GRID_SIZE) begin
			if (shape[tetris_geom_pkg::grid_bit(grid_row, grid_col)])
				query_tile = color;
		end
	end

endmodule : cell_lookup

`default_nettype wire

/* rtl/cmd_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo #(
	parameter type payload_t = logic,
	parameter int CMD_DEPTH = 2
) (
	input logic clk,
	input logic reset_n,
	input logic in_valid,
	input payload_t in_data,
	output logic head_valid,
	output payload_t head_data,
	input logic pop,
	output logic credit
);
	localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
	localparam int CNT_W = $clog2(CMD_DEPTH + 1);

	payload_t mem [CMD_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	function automatic logic [PTR_W-1:0] bump(logic [PTR_W-1:0] p);
		return (p == PTR_W'(CMD_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign head_valid = (count != '0);
	assign head_data = mem[rd_ptr];

	// The sender holds a credit per free slot, so a write never meets a full queue
	always_ff @(posedge clk) begin
		if (in_valid)
			mem[wr_ptr] <= in_data;
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			if (in_valid)
				wr_ptr <= bump(wr_ptr);
			if (pop)
				rd_ptr <= bump(rd_ptr);
			count <= count + CNT_W'(in_valid) - CNT_W'(pop);
			// One credit back per retired command
			credit <= pop;
		end
	end

endmodule : cmd_fifo

`default_nettype wire

/* rtl/move_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module move_ctrl (
	input logic clk,
	input logic reset_n,
	input logic head_valid,
	input tetris_types_pkg::buttons_t head_buttons,
	output logic pop,
	output tetris_types_pkg::spin_t spin,
	output logic commit,
	output logic spawn,
	input tetris_types_pkg::shape_t cand_shape,
	output tetris_geom_pkg::row_t piece_row,
	output tetris_geom_pkg::col_t piece_col,
	output logic playing
);
	tetris_types_pkg::play_state_t state;
	tetris_geom_pkg::row_t cand_row;
	tetris_geom_pkg::col_t cand_col;
	logic move_req;
	logic collide;

	// Every queued command is consumed in the cycle it reaches the head
	assign pop = head_valid;
	assign playing = (state == tetris_types_pkg::FALLING);

	// First pressed button wins: down, left, right, cw, ccw
	always_comb begin
		cand_row = piece_row;
		cand_col = piece_col;
		spin = tetris_types_pkg::SPIN_NONE;
		move_req = 1'b0;
		if (playing) begin
			move_req = 1'b1;
			if (head_buttons.down)
				cand_row = piece_row + 6'sd1;
			else if (head_buttons.left)
				cand_col = piece_col - 5'sd1;
			else if (head_buttons.right)
				cand_col = piece_col + 5'sd1;
			else if (head_buttons.cw)
				spin = tetris_types_pkg::SPIN_CW;
			else if (head_buttons.ccw)
				spin = tetris_types_pkg::SPIN_CCW;
			else
				move_req = 1'b0;
		end
	end

	bound_check bound_i (
		.shape(cand_shape),
		.row(cand_row),
		.col(cand_col),
		.collide(collide)
	);

	// A blocked side move or spin is simply dropped, a blocked fall locks
	always_comb begin
		commit = 1'b0;
		spawn = 1'b0;
		if (head_valid) begin
			if (!playing)
				spawn = |head_buttons;
			else if (move_req) begin
				if (!collide)
					commit = 1'b1;
				else if (head_buttons.down)
					spawn = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= tetris_types_pkg::IDLE;
			piece_row <= tetris_geom_pkg::SPAWN_ROW;
			piece_col <= tetris_geom_pkg::SPAWN_COL;
		end else if (spawn) begin
			state <= tetris_types_pkg::FALLING;
			piece_row <= tetris_geom_pkg::SPAWN_ROW;
			piece_col <= tetris_geom_pkg::SPAWN_COL;
		end else if (commit) begin
			piece_row <= cand_row;
			piece_col <= cand_col;
		end
	end

endmodule : move_ctrl

`default_nettype wire

/* rtl/piece_rng.sv */
`timescale 1ns/1ps
`default_nettype none

module piece_rng (
	input logic clk,
	input logic reset_n,
	input logic spawn,
	output tetris_types_pkg::tile_t next_tile
);
	logic [7:0] lfsr;
	logic feedback;

	assign feedback = lfsr[3] ^ lfsr[4] ^ lfsr[5] ^ lfsr[7];

	// Zero is not a piece, fold it onto J
	assign next_tile = tetris_types_pkg::tile_t'((lfsr[2:0] == 3'd0) ? 3'd1 : lfsr[2:0]);

	always_ff @(posedge clk) begin
		if (!reset_n)
			lfsr <= tetris_geom_pkg::LFSR_SEED;
		else if (spawn)
			lfsr <= {lfsr[6:0], feedback};
	end

endmodule : piece_rng

`default_nettype wire

/* rtl/piece_shape.sv */
`timescale 1ns/1ps
`default_nettype none

module piece_shape (
	input logic clk,
	input logic reset_n,
	input logic spawn,
	input tetris_types_pkg::tile_t next_tile,
	input tetris_types_pkg::spin_t spin,
	input logic commit,
	output tetris_types_pkg::shape_t cand_shape,
	output tetris_types_pkg::shape_t shape,
	output tetris_types_pkg::tile_t color
);
	tetris_types_pkg::shape_t load_shape;

	// Spawn patterns, one row per nibble
	always_comb begin
		case (next_tile)
			tetris_types_pkg::TILE_BLUE:   load_shape = 16'b0000_1000_1110_0000;
			tetris_types_pkg::TILE_GREEN:  load_shape = 16'b0000_0110_1100_0000;
			tetris_types_pkg::TILE_CYAN:   load_shape = 16'b0000_0000_1111_0000;
			tetris_types_pkg::TILE_RED:    load_shape = 16'b0000_1100_0110_0000;
			tetris_types_pkg::TILE_PURPLE: load_shape = 16'b0000_0100_1110_0000;
			tetris_types_pkg::TILE_YELLOW: load_shape = 16'b0000_0110_0110_0000;
			tetris_types_pkg::TILE_WHITE:  load_shape = 16'b0000_0010_1110_0000;
			default:                       load_shape = 16'b0;
		endcase
	end

	// Rotation network
	always_comb begin
		cand_shape = shape;
		if (spin != tetris_types_pkg::SPIN_NONE) begin
			if (color == tetris_types_pkg::TILE_CYAN) begin
				// I flips across the main diagonal of the whole grid
				for (int r = 0; r < tetris_geom_pkg::GRID_SIZE; r++) begin
					for (int c = 0; c < tetris_geom_pkg::GRID_SIZE; c++) begin
						cand_shape[tetris_geom_pkg::grid_bit(r, c)] =
							shape[tetris_geom_pkg::grid_bit(c, r)];
					end
				end
			end else if (color != tetris_types_pkg::TILE_YELLOW) begin
				// 3x3 box sits on grid rows 1..3, columns 0..2
				for (int r = 0; r < 3; r++) begin
					for (int c = 0; c < 3; c++) begin
						if (spin == tetris_types_pkg::SPIN_CW)
							cand_shape[tetris_geom_pkg::grid_bit(r + 1, c)] =
								shape[tetris_geom_pkg::grid_bit(3 - c, r)];
						else
							cand_shape[tetris_geom_pkg::grid_bit(r + 1, c)] =
								shape[tetris_geom_pkg::grid_bit(c + 1, 2 - r)];
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			shape <= '0;
			color <= tetris_types_pkg::TILE_EMPTY;
		end else if (spawn) begin
			shape <= load_shape;
			color <= next_tile;
		end else if (commit) begin
			shape <= cand_shape;
		end
	end

endmodule : piece_shape

`default_nettype wire

/* rtl/tetris_geom_pkg.sv */
`default_nettype none

package tetris_geom_pkg;

	localparam int WELL_ROWS = 20;
	localparam int WELL_COLS = 10;
	localparam int GRID_SIZE = 4;

	// Piece position, signed so a rotated piece may hang left of column 0
	typedef logic signed [5:0] row_t;
	typedef logic signed [4:0] col_t;

	// Well cell addresses on the query port
	typedef logic [4:0] cell_row_t;
	typedef logic [3:0] cell_col_t;

	localparam row_t SPAWN_ROW = 6'sd0;
	localparam col_t SPAWN_COL = 5'sd3;

	localparam logic [7:0] LFSR_SEED = 8'h01;

	// Bit index of grid cell (r, c) inside a shape word
	function automatic logic [3:0] grid_bit(int r, int c);
		return 4'(GRID_SIZE * GRID_SIZE - 1 - GRID_SIZE * r - c);
	endfunction

endpackage : tetris_geom_pkg

`default_nettype wire

/* rtl/tetris_piece_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tetris_piece_top #(
	parameter int CMD_DEPTH = 2
) (
	input logic clk,
	input logic reset_n,
	input logic cmd_valid,
	input tetris_types_pkg::buttons_t cmd_buttons,
	output logic cmd_credit,
	input tetris_geom_pkg::cell_row_t query_row,
	input tetris_geom_pkg::cell_col_t query_col,
	output tetris_types_pkg::tile_t query_tile,
	output logic playing,
	output tetris_geom_pkg::row_t piece_row,
	output tetris_geom_pkg::col_t piece_col,
	output tetris_types_pkg::tile_t piece_tile
);
	logic head_valid;
	tetris_types_pkg::buttons_t head_buttons;
	logic pop;
	logic spawn;
	logic commit;
	tetris_types_pkg::spin_t spin;
	tetris_types_pkg::tile_t next_tile;
	tetris_types_pkg::shape_t cand_shape;
	tetris_types_pkg::shape_t shape;

	cmd_fifo #(
		.payload_t(tetris_types_pkg::buttons_t),
		.CMD_DEPTH(CMD_DEPTH)
	) fifo_i (
		.clk(clk),
		.reset_n(reset_n),
		.in_valid(cmd_valid),
		.in_data(cmd_buttons),
		.head_valid(head_valid),
		.head_data(head_buttons),
		.pop(pop),
		.credit(cmd_credit)
	);

	piece_rng rng_i (
		.clk(clk),
		.reset_n(reset_n),
		.spawn(spawn),
		.next_tile(next_tile)
	);

	piece_shape shape_i (
		.clk(clk),
		.reset_n(reset_n),
		.spawn(spawn),
		.next_tile(next_tile),
		.spin(spin),
		.commit(commit),
		.cand_shape(cand_shape),
		.shape(shape),
		.color(piece_tile)
	);

	move_ctrl ctrl_i (
		.clk(clk),
		.reset_n(reset_n),
		.head_valid(head_valid),
		.head_buttons(head_buttons),
		.pop(pop),
		.spin(spin),
		.commit(commit),
		.spawn(spawn),
		.cand_shape(cand_shape),
		.piece_row(piece_row),
		.piece_col(piece_col),
		.playing(playing)
	);

	cell_lookup lookup_i (
		.shape(shape),
		.color(piece_tile),
		.piece_row(piece_row),
		.piece_col(piece_col),
		.playing(playing),
		.query_row(query_row),
		.query_col(query_col),
		.query_tile(query_tile)
	);

endmodule : tetris_piece_top

`default_nettype wire

/* rtl/tetris_types_pkg.sv */
`default_nettype none

package tetris_types_pkg;

	// Tile colors, one per tetromino kind
	typedef enum logic [2:0] {
		TILE_EMPTY  = 3'd0,
		TILE_BLUE   = 3'd1, // J
		TILE_GREEN  = 3'd2, // S
		TILE_CYAN   = 3'd3, // I
		TILE_RED    = 3'd4, // Z
		TILE_PURPLE = 3'd5, // T
		TILE_YELLOW = 3'd6, // O
		TILE_WHITE  = 3'd7  // L
	} tile_t;

	typedef struct packed {
		logic down;
		logic left;
		logic right;
		logic cw;
		logic ccw;
	} buttons_t;

	typedef enum logic {
		IDLE    = 1'b0,
		FALLING = 1'b1
	} play_state_t;

	typedef enum logic [1:0] {
		SPIN_NONE = 2'b00,
		SPIN_CW   = 2'b01,
		SPIN_CCW  = 2'b10
	} spin_t;

	// Bits 15..12 hold grid row 0, MSB of a row is grid column 0
	typedef logic [15:0] shape_t;

endpackage : tetris_types_pkg

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator and run; the status follows the testbench verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module tetris_piece_tb \
	-o tetris_piece_sim &&
./obj_dir/tetris_piece_sim | tee /dev/stderr | grep -qF "Simulation finished: PASS" &&
echo "run.sh: simulation passed" && exit 0 ||
{ echo "run.sh: simulation failed"; exit 1; }

/* verif/tetris_piece_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module tetris_piece_asserts #(
	parameter int CMD_DEPTH = 2
) (
	input logic clk,
	input logic reset_n,
	input logic cmd_valid,
	input logic cmd_credit,
	input logic pop,
	input logic playing,
	input tetris_types_pkg::shape_t shape,
	input tetris_geom_pkg::row_t piece_row,
	input tetris_geom_pkg::col_t piece_col
);
	int fill;
	int outstanding;
	logic collide;

	// Walls and floor seen by the committed piece
	bound_check bound_i (
		.shape(shape),
		.row(piece_row),
		.col(piece_col),
		.collide(collide)
	);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			fill <= 0;
			outstanding <= 0;
		end else begin
			fill <= fill + int'(cmd_valid) - int'(pop);
			outstanding <= outstanding + int'(cmd_valid) - int'(cmd_credit);
		end
	end

	no_beat_when_full: assert property (@(posedge clk) disable iff (!reset_n)
		cmd_valid |-> fill < CMD_DEPTH)
		else $error("command beat arrived while the FIFO was full");

	credit_has_beat: assert property (@(posedge clk) disable iff (!reset_n)
		cmd_credit |-> outstanding > 0)
		else $error("credit returned without an accepted beat");

	piece_inside_well: assert property (@(posedge clk) disable iff (!reset_n)
		playing |-> !collide)
		else $error("committed piece position overlaps a wall or the floor");

endmodule : tetris_piece_asserts

bind tetris_piece_top tetris_piece_asserts #(
	.CMD_DEPTH(CMD_DEPTH)
) asserts_i (
	.clk(clk),
	.reset_n(reset_n),
	.cmd_valid(cmd_valid),
	.cmd_credit(cmd_credit),
	.pop(pop),
	.playing(playing),
	.shape(shape),
	.piece_row(piece_row),
	.piece_col(piece_col)
);

`default_nettype wire

/* verif/tetris_piece_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tetris_piece_tb;

	localparam int CMD_DEPTH = 2;
	localparam int WAIT_LIMIT = 50;
	localparam int ROWS = 20;
	localparam int COLS = 10;

	localparam tetris_types_pkg::buttons_t BTN_DOWN = 5'b10000;
	localparam tetris_types_pkg::buttons_t BTN_LEFT = 5'b01000;
	localparam tetris_types_pkg::buttons_t BTN_RIGHT = 5'b00100;
	localparam tetris_types_pkg::buttons_t BTN_CW = 5'b00010;
	localparam tetris_types_pkg::buttons_t BTN_CCW = 5'b00001;

	logic clk;
	logic reset_n;
	logic cmd_valid;
	tetris_types_pkg::buttons_t cmd_buttons;
	logic cmd_credit;
	tetris_geom_pkg::cell_row_t query_row;
	tetris_geom_pkg::cell_col_t query_col;
	tetris_types_pkg::tile_t query_tile;
	logic playing;
	tetris_geom_pkg::row_t piece_row;
	tetris_geom_pkg::col_t piece_col;
	tetris_types_pkg::tile_t piece_tile;

	// Reference model state
	logic [7:0] m_lfsr;
	logic [15:0] m_shape;
	tetris_types_pkg::tile_t m_color;
	int m_row;
	int m_col;
	logic m_playing;
	int m_spawns;

	logic [31:0] rng_state;
	int credits;
	int sent;
	int returned;

	tetris_piece_top #(
		.CMD_DEPTH(CMD_DEPTH)
	) dut_i (
		.clk(clk),
		.reset_n(reset_n),
		.cmd_valid(cmd_valid),
		.cmd_buttons(cmd_buttons),
		.cmd_credit(cmd_credit),
		.query_row(query_row),
		.query_col(query_col),
		.query_tile(query_tile),
		.playing(playing),
		.piece_row(piece_row),
		.piece_col(piece_col),
		.piece_tile(piece_tile)
	);

	always #20 clk = ~clk;

	function automatic logic next_rand_bit();
		logic out;
		out = rng_state[0];
		rng_state = rng_state >> 1;
		if (out)
			rng_state = rng_state ^ 32'h80200003;
		return out;
	endfunction

	function automatic int rand_bits(int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = (v << 1) | int'(next_rand_bit());
		return v;
	endfunction

	function automatic logic [3:0] bit_at(int r, int c);
		return 4'(15 - 4 * r - c);
	endfunction

	function automatic logic [15:0] spawn_shape(tetris_types_pkg::tile_t kind);
		case (kind)
			tetris_types_pkg::TILE_BLUE:   return 16'h08e0;
			tetris_types_pkg::TILE_GREEN:  return 16'h06c0;
			tetris_types_pkg::TILE_CYAN:   return 16'h00f0;
			tetris_types_pkg::TILE_RED:    return 16'h0c60;
			tetris_types_pkg::TILE_PURPLE: return 16'h04e0;
			tetris_types_pkg::TILE_YELLOW: return 16'h0660;
			tetris_types_pkg::TILE_WHITE:  return 16'h02e0;
			default:                       return 16'h0000;
		endcase
	endfunction

	function automatic tetris_types_pkg::tile_t lfsr_tile(logic [7:0] s);
		if (s[2:0] == 3'd0)
			return tetris_types_pkg::TILE_BLUE;
		return tetris_types_pkg::tile_t'(s[2:0]);
	endfunction

	function automatic logic [7:0] lfsr_step(logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	function automatic logic [15:0] rotate(logic [15:0] s, tetris_types_pkg::tile_t kind,
		logic cw);
		logic [15:0] res;
		res = s;
		if (kind == tetris_types_pkg::TILE_CYAN) begin
			for (int r = 0; r < 4; r++)
				for (int c = 0; c < 4; c++)
					res[bit_at(r, c)] = s[bit_at(c, r)];
		end else if (kind != tetris_types_pkg::TILE_YELLOW) begin
			// Box cell (r, c) sits at grid row r + 1
			for (int r = 0; r < 3; r++)
				for (int c = 0; c < 3; c++)
					res[bit_at(r + 1, c)] = cw ? s[bit_at(2 - c + 1, r)] : s[bit_at(c + 1, 2 - r)];
		end
		return res;
	endfunction

	function automatic logic hits_wall(logic [15:0] s, int row, int col);
		logic hit;
		hit = 1'b0;
		for (int r = 0; r < 4; r++)
			for (int c = 0; c < 4; c++)
				if (s[bit_at(r, c)] && (row + r >= ROWS || col + c < 0 || col + c >= COLS))
					hit = 1'b1;
		return hit;
	endfunction

	function automatic tetris_types_pkg::tile_t model_cell(int r, int c);
		int gr;
		int gc;
		gr = r - m_row;
		gc = c - m_col;
		if (m_playing && gr >= 0 && gr < 4 && gc >= 0 && gc < 4 && m_shape[bit_at(gr, gc)])
			return m_color;
		return tetris_types_pkg::TILE_EMPTY;
	endfunction

	task automatic spawn_model();
		m_color = lfsr_tile(m_lfsr);
		m_shape = spawn_shape(m_color);
		m_row = 0;
		m_col = 3;
		m_lfsr = lfsr_step(m_lfsr);
		m_playing = 1'b1;
		m_spawns++;
	endtask

	task automatic apply_model(tetris_types_pkg::buttons_t b);
		int col;
		logic [15:0] s;
		col = m_col;
		s = m_shape;
		if (!m_playing) begin
			if (b != '0)
				spawn_model();
		end else if (b.down) begin
			// A blocked fall locks the piece
			if (hits_wall(s, m_row + 1, col))
				spawn_model();
			else
				m_row = m_row + 1;
		end else if (b.left || b.right || b.cw || b.ccw) begin
			if (b.left)
				col = col - 1;
			else if (b.right)
				col = col + 1;
			else
				s = rotate(s, m_color, b.cw);
			if (!hits_wall(s, m_row, col)) begin
				m_col = col;
				m_shape = s;
			end
		end
	endtask

	task automatic stop_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "testbench stopped at the first error");
	endtask

	task automatic compare_tile(string name, tetris_types_pkg::tile_t exp,
		tetris_types_pkg::tile_t act);
		if (exp !== act) begin
			$display("ERR %s expected %0d actual %0d", name, exp, act);
			stop_run();
		end
	endtask

	task automatic compare_row(string name, tetris_geom_pkg::row_t exp,
		tetris_geom_pkg::row_t act);
		if (exp !== act) begin
			$display("ERR %s expected %0d actual %0d", name, exp, act);
			stop_run();
		end
	endtask

	task automatic compare_col(string name, tetris_geom_pkg::col_t exp,
		tetris_geom_pkg::col_t act);
		if (exp !== act) begin
			$display("ERR %s expected %0d actual %0d", name, exp, act);
			stop_run();
		end
	endtask

	task automatic compare_bit(string name, logic exp, logic act);
		if (exp !== act) begin
			$display("ERR %s expected %b actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic compare_count(string name, int exp, int act);
		if (exp != act) begin
			$display("ERR %s expected %0d actual %0d", name, exp, act);
			stop_run();
		end
	endtask

	// Advance to the next drive slot and count any credit pulse of the last cycle
	task automatic tick();
		@(posedge clk);
		#1;
		if (cmd_credit) begin
			credits++;
			returned++;
		end
	endtask

	task automatic send_cmd(tetris_types_pkg::buttons_t b);
		int waited;
		waited = 0;
		while (credits == 0) begin
			if (waited == WAIT_LIMIT) begin
				$display("timeout: no credit came back within %0d cycles", WAIT_LIMIT);
				stop_run();
			end
			waited++;
			tick();
		end
		cmd_valid = 1'b1;
		cmd_buttons = b;
		credits--;
		sent++;
		apply_model(b);
		tick();
		cmd_valid = 1'b0;
	endtask

	task automatic drain_queue();
		int waited;
		waited = 0;
		while (credits != CMD_DEPTH) begin
			if (waited == WAIT_LIMIT) begin
				$display("timeout: command queue did not drain within %0d cycles", WAIT_LIMIT);
				stop_run();
			end
			waited++;
			tick();
		end
	endtask

	task automatic check_state(string name);
		compare_bit({name, " playing"}, m_playing, playing);
		compare_row({name, " row"}, tetris_geom_pkg::row_t'(m_row), piece_row);
		compare_col({name, " col"}, tetris_geom_pkg::col_t'(m_col), piece_col);
		compare_tile({name, " piece tile"}, m_color, piece_tile);
		// One queried cell per cycle, read back in the next drive slot
		for (int r = 0; r < ROWS; r++) begin
			for (int c = 0; c < COLS; c++) begin
				query_row = tetris_geom_pkg::cell_row_t'(r);
				query_col = tetris_geom_pkg::cell_col_t'(c);
				tick();
				compare_tile($sformatf("%s cell %0d,%0d", name, r, c), model_cell(r, c),
					query_tile);
			end
		end
	endtask

	task automatic step_and_check(tetris_types_pkg::buttons_t b, string name);
		send_cmd(b);
		drain_queue();
		check_state(name);
	endtask

	initial begin
		logic [4:0] raw;
		int len;
		int start;
		int n;
		clk = 1'b0;
		reset_n = 1'b0;
		cmd_valid = 1'b0;
		cmd_buttons = '0;
		query_row = '0;
		query_col = '0;
		rng_state = 32'hff6ebc5d;
		credits = CMD_DEPTH;
		sent = 0;
		returned = 0;
		m_lfsr = 8'h01;
		m_shape = '0;
		m_color = tetris_types_pkg::TILE_EMPTY;
		m_row = 0;
		m_col = 3;
		m_playing = 1'b0;
		m_spawns = 0;
		repeat (3) tick();
		reset_n = 1'b1;
		check_state("reset");

		// The first command leaves IDLE with the first piece
		step_and_check(BTN_LEFT, "start");

		for (int p = 0; p < 8; p++) begin
			step_and_check(BTN_CW, "spin cw");
			step_and_check(BTN_CCW, "spin ccw");
			step_and_check(BTN_CW, "spin cw again");
			repeat (5) step_and_check(BTN_LEFT, "left wall");
			step_and_check(BTN_CCW, "left wall ccw");
			step_and_check(BTN_CW, "left wall cw");
			repeat (8) step_and_check(BTN_RIGHT, "right wall");
			step_and_check(BTN_CCW, "right wall ccw");
			step_and_check(BTN_CW, "right wall cw");
			start = m_spawns;
			n = 0;
			while (m_spawns == start) begin
				if (n == 25) begin
					$display("piece did not lock within 25 down moves");
					stop_run();
				end
				step_and_check(BTN_DOWN, "drop");
				n++;
			end
		end

		// Random bursts of up to a full set of credits
		for (int k = 0; k < 40; k++) begin
			len = rand_bits(2) % CMD_DEPTH + 1;
			sent = 0;
			returned = 0;
			for (int i = 0; i < len; i++) begin
				raw = 5'(rand_bits(5));
				send_cmd(raw);
			end
			drain_queue();
			check_state("burst");
			compare_count("burst credits", sent, returned);
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule : tetris_piece_tb

`default_nettype wire
